// File: sources.f
rtl/seg_geom_pkg.sv
rtl/seg_ctrl_pkg.sv
rtl/score_if.sv
rtl/frame_ram.sv
rtl/image_loader.sv
rtl/class_scorer.sv
rtl/argmax_unit.sv
rtl/seg_sequencer.sv
rtl/seg_top.sv
tb/tb_clock.sv
tb/seg_tb.sv

// File: run.sh
#!/bin/sh
# Compiles the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module seg_tb -f sources.f -o seg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/seg_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// File: tb/seg_tb.sv
// Testbench for seg_top with word memory model, reference classifier and frame table
`timescale 1ns/1ns

module seg_tb;

    localparam int WORDS      = seg_ctrl_pkg::WORDS_PER_FRAME;
    localparam int BYTES      = seg_geom_pkg::NUM_BYTES;
    localparam int PIX        = seg_geom_pkg::NUM_PIX;
    localparam int MAX_LAT    = 3;
    localparam int NUM_FRAMES = 9;
    localparam logic [31:0] SEED = 32'ha00f_54f6;
    // Worst case load, classify and readback per frame plus slack
    localparam int FRAME_CYCLES =
        WORDS * (seg_ctrl_pkg::BYTES_PER_WORD + 1 + MAX_LAT) + BYTES + PIX + 100;
    localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_CYCLES + 500;

    typedef struct packed {
        logic       rnd;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [1:0] exp_label;
    } frame_entry_t;

    // Constant colours carry a hand-computed label and frames 4 and 8 are ties
    localparam frame_entry_t FRAMES [NUM_FRAMES] = '{
        '{1'b0, 8'd200, 8'd10,  8'd10,  2'd0},
        '{1'b0, 8'd10,  8'd200, 8'd10,  2'd1},
        '{1'b1, 8'd0,   8'd0,   8'd0,   2'd0},
        '{1'b0, 8'd10,  8'd10,  8'd200, 2'd2},
        '{1'b0, 8'd100, 8'd100, 8'd0,   2'd0},
        '{1'b1, 8'd0,   8'd0,   8'd0,   2'd0},
        '{1'b0, 8'd250, 8'd250, 8'd250, 2'd3},
        '{1'b1, 8'd0,   8'd0,   8'd0,   2'd0},
        '{1'b0, 8'd0,   8'd0,   8'd0,   2'd0}
    };

    logic                                clk;
    logic                                rst;
    logic                                start_process;
    logic                                processing_done;
    logic                                mem_req;
    logic [seg_ctrl_pkg::MEM_ADDR_W-1:0] mem_addr;
    logic                                mem_ack = 1'b0;
    logic [31:0]                         mem_rdata = '0;
    seg_geom_pkg::pix_idx_t              label_addr;
    seg_geom_pkg::label_t                label;
    logic [9:0]                          leds;

    logic [31:0] mem_words [WORDS];
    int          lat_tab [WORDS];
    logic [7:0]  img [BYTES];
    logic [31:0] rng;
    int          req_count = 0;
    int          mem_errors = 0;
    int          errors;
    int          passed;
    int          failed;
    int          cycles = 0;

    tb_clock #(.PERIOD(40), .RST_CYCLES(5)) u_tb_clock (.clk(clk), .rst(rst));

    seg_top u_seg_top (
        .clk             (clk),
        .rst             (rst),
        .start_process   (start_process),
        .processing_done (processing_done),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .mem_ack         (mem_ack),
        .mem_rdata       (mem_rdata),
        .label_addr      (label_addr),
        .label           (label),
        .leds            (leds)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Class rule from the package tables where the first maximum wins
    function automatic int ref_label(input logic [7:0] r, input logic [7:0] g,
                                     input logic [7:0] b);
        logic [7:0] ch [3];
        int sc;
        int best;
        int best_score;
        ch[0] = r;
        ch[1] = g;
        ch[2] = b;
        best = 0;
        best_score = 0;
        for (int c = 0; c < seg_geom_pkg::NUM_CLASSES; c++) begin
            sc = int'(seg_geom_pkg::CLASS_BIAS[c]);
            for (int k = 0; k < seg_geom_pkg::NUM_CH; k++) begin
                sc = sc + int'(seg_geom_pkg::CLASS_WEIGHTS[c][k]) * int'(ch[k]);
            end
            if (c == 0 || sc > best_score) begin
                best = c;
                best_score = sc;
            end
        end
        return best;
    endfunction

    // Word memory that acks each request after a per-word latency
    always begin
        int idx;
        logic [seg_ctrl_pkg::MEM_ADDR_W-1:0] addr_seen;
        @(posedge clk);
        #2;
        if (!rst && mem_req) begin
            addr_seen = mem_addr;
            idx = int'(addr_seen);
            if (idx != req_count % WORDS) begin
                mem_errors++;
                $display("mismatch at %0t: request address %0d, expected %0d",
                         $time, idx, req_count % WORDS);
            end
            if (idx >= WORDS) begin
                idx = 0;
            end
            req_count++;
            repeat (lat_tab[idx]) begin
                @(posedge clk);
                #2;
                if (!mem_req || mem_addr != addr_seen) begin
                    mem_errors++;
                    $display("at %0t the request dropped or its address moved before the ack",
                             $time);
                end
            end
            mem_ack = 1'b1;
            mem_rdata = mem_words[idx];
            @(posedge clk);
            #2;
            mem_ack = 1'b0;
            if (mem_req) begin
                mem_errors++;
                $display("at %0t the request stayed high in the cycle after its ack", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_reset_state();
        int err0;
        err0 = errors + mem_errors;
        if (processing_done !== 1'b1 || mem_req !== 1'b0 || leds !== 10'd0) begin
            errors++;
            $display("mismatch at %0t: after reset done=%b req=%b leds=%b",
                     $time, processing_done, mem_req, leds);
        end
        report_test("reset state", err0);
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors + mem_errors == err0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors + mem_errors - err0);
        end
    endtask

    task automatic run_frame(input int f);
        frame_entry_t e;
        int err0;
        int exp_label;
        e = FRAMES[f];
        err0 = errors + mem_errors;
        for (int i = 0; i < BYTES; i++) begin
            if (e.rnd) begin
                rng = xorshift32(rng);
                img[i] = rng[7:0];
            end else begin
                img[i] = (i % 3 == 0) ? e.r : ((i % 3 == 1) ? e.g : e.b);
            end
        end
        for (int w = 0; w < WORDS; w++) begin
            mem_words[w] = {img[4*w+3], img[4*w+2], img[4*w+1], img[4*w]};
            rng = xorshift32(rng);
            lat_tab[w] = int'(rng[1:0]);
        end
        if (!e.rnd && ref_label(e.r, e.g, e.b) != int'(e.exp_label)) begin
            errors++;
            $display("frame %0d: the reference classifier disagrees with the table", f);
        end
        start_process = 1'b1;
        @(posedge clk);
        #2;
        start_process = 1'b0;
        if (processing_done !== 1'b0 || leds !== 10'd1) begin
            errors++;
            $display("mismatch at %0t: after start done=%b leds=%b", $time, processing_done, leds);
        end
        repeat (10) begin
            @(posedge clk);
            #2;
        end
        // Start while busy must not launch a second load
        start_process = 1'b1;
        @(posedge clk);
        #2;
        start_process = 1'b0;
        while (!processing_done) begin
            if (leds[2] !== 1'b0) begin
                errors++;
                $display("mismatch at %0t: leds bit 2 set while busy", $time);
            end
            @(posedge clk);
            #2;
        end
        if (leds !== 10'd4) begin
            errors++;
            $display("mismatch at %0t: leds=%b after frame, expected 0000000100", $time, leds);
        end
        if (req_count != (f + 1) * WORDS) begin
            errors++;
            $display("mismatch at %0t: %0d requests so far, expected %0d",
                     $time, req_count, (f + 1) * WORDS);
        end
        for (int p = 0; p < PIX; p++) begin
            label_addr = seg_geom_pkg::pix_idx_t'(p);
            @(posedge clk);
            #2;
            exp_label = e.rnd ? ref_label(img[3*p], img[3*p+1], img[3*p+2]) : int'(e.exp_label);
            if (int'(label) != exp_label) begin
                errors++;
                $display("mismatch at %0t: frame %0d pixel %0d label %0d, expected %0d",
                         $time, f, p, label, exp_label);
            end
        end
        report_test($sformatf("frame %0d (%s)", f, e.rnd ? "random" : "constant"), err0);
    endtask

    initial begin
        start_process = 1'b0;
        label_addr = '0;
        rng = SEED;
        errors = 0;
        passed = 0;
        failed = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        #2;
        check_reset_state();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors + mem_errors);
        if (failed == 0 && errors + mem_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// File: rtl/seg_top.sv
// Segmentation engine top level with sequencer, loader, scorer, argmax and frame memories
`timescale 1ns/1ns

module seg_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start_process,
    output logic                                processing_done,
    output logic                                mem_req,
    output logic [seg_ctrl_pkg::MEM_ADDR_W-1:0] mem_addr,
    input  logic                                mem_ack,
    input  logic [31:0]                         mem_rdata,
    input  seg_geom_pkg::pix_idx_t              label_addr,
    output seg_geom_pkg::label_t                label,
    output logic [9:0]                          leds
);

    logic                    load_start;
    logic                    class_start;
    logic                    load_done;
    logic                    frame_done;
    logic                    in_we;
    seg_geom_pkg::byte_idx_t in_waddr;
    seg_geom_pkg::pixel_t    in_wdata;
    seg_geom_pkg::byte_idx_t in_raddr;
    seg_geom_pkg::pixel_t    in_rdata;
    logic                    lbl_we;
    seg_geom_pkg::pix_idx_t  lbl_addr;
    seg_geom_pkg::label_t    lbl_data;

    score_if u_score_if ();

    seg_sequencer u_seg_sequencer (
        .clk             (clk),
        .rst             (rst),
        .start_process   (start_process),
        .load_done       (load_done),
        .frame_done      (frame_done),
        .load_start      (load_start),
        .class_start     (class_start),
        .processing_done (processing_done),
        .leds            (leds)
    );

    image_loader u_image_loader (
        .clk        (clk),
        .rst        (rst),
        .load_start (load_start),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .wr_en      (in_we),
        .wr_addr    (in_waddr),
        .wr_data    (in_wdata),
        .load_done  (load_done)
    );

    // Channel bytes of the whole frame
    frame_ram #(
        .DEPTH (seg_geom_pkg::NUM_BYTES),
        .WIDTH ($bits(seg_geom_pkg::pixel_t))
    ) u_input_ram (
        .clk   (clk),
        .we    (in_we),
        .waddr (in_waddr),
        .wdata (in_wdata),
        .raddr (in_raddr),
        .rdata (in_rdata)
    );

    class_scorer u_class_scorer (
        .clk         (clk),
        .rst         (rst),
        .class_start (class_start),
        .rd_addr     (in_raddr),
        .rd_data     (in_rdata),
        .sif         (u_score_if.scorer)
    );

    argmax_unit u_argmax_unit (
        .clk        (clk),
        .rst        (rst),
        .sif        (u_score_if.picker),
        .lbl_we     (lbl_we),
        .lbl_addr   (lbl_addr),
        .lbl_data   (lbl_data),
        .frame_done (frame_done)
    );

    // Read side is the external label port
    frame_ram #(
        .DEPTH (seg_geom_pkg::NUM_PIX),
        .WIDTH ($bits(seg_geom_pkg::label_t))
    ) u_label_ram (
        .clk   (clk),
        .we    (lbl_we),
        .waddr (lbl_addr),
        .wdata (lbl_data),
        .raddr (label_addr),
        .rdata (label)
    );

endmodule

// File: rtl/seg_sequencer.sv
// Main sequencer FSM for load and classify phases, with status LEDs
`timescale 1ns/1ns

module seg_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_process,
    input  logic       load_done,
    input  logic       frame_done,
    output logic       load_start,
    output logic       class_start,
    output logic       processing_done,
    output logic [9:0] leds
);

    seg_ctrl_pkg::seq_state_t state;
    logic frame_flag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= seg_ctrl_pkg::SEQ_IDLE;
            load_start  <= 1'b0;
            class_start <= 1'b0;
            frame_flag  <= 1'b0;
        end else begin
            load_start  <= 1'b0;
            class_start <= 1'b0;
            case (state)
                // Start is ignored anywhere else
                seg_ctrl_pkg::SEQ_IDLE: begin
                    if (start_process) begin
                        state      <= seg_ctrl_pkg::SEQ_LOAD;
                        load_start <= 1'b1;
                        frame_flag <= 1'b0;
                    end
                end
                seg_ctrl_pkg::SEQ_LOAD: begin
                    if (load_done) begin
                        state       <= seg_ctrl_pkg::SEQ_CLASSIFY;
                        class_start <= 1'b1;
                    end
                end
                seg_ctrl_pkg::SEQ_CLASSIFY: begin
                    if (frame_done) begin
                        state      <= seg_ctrl_pkg::SEQ_IDLE;
                        frame_flag <= 1'b1;
                    end
                end
                default: begin
                    state <= seg_ctrl_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    assign processing_done = (state == seg_ctrl_pkg::SEQ_IDLE);

    // State in bits 1:0, sticky frame-complete flag in bit 2
    assign leds = {7'b0, frame_flag, state};

endmodule

// File: rtl/argmax_unit.sv
// Argmax stage that picks the winning class and writes the label memory
`timescale 1ns/1ns

module argmax_unit (
    input  logic                   clk,
    input  logic                   rst,
    score_if.picker                sif,
    output logic                   lbl_we,
    output seg_geom_pkg::pix_idx_t lbl_addr,
    output seg_geom_pkg::label_t   lbl_data,
    output logic                   frame_done
);

    seg_geom_pkg::score_t s          [seg_geom_pkg::NUM_CLASSES];
    seg_geom_pkg::score_t pair_score [seg_geom_pkg::NUM_CLASSES / 2];
    seg_geom_pkg::label_t pair_idx   [seg_geom_pkg::NUM_CLASSES / 2];
    seg_geom_pkg::label_t winner;

    // Two-level tree where the upper side wins only when strictly greater
    always_comb begin
        for (int c = 0; c < seg_geom_pkg::NUM_CLASSES; c++) begin
            s[c] = sif.scores[c];
        end
        for (int k = 0; k < seg_geom_pkg::NUM_CLASSES / 2; k++) begin
            if (s[2*k+1] > s[2*k]) begin
                pair_score[k] = s[2*k+1];
                pair_idx[k]   = seg_geom_pkg::label_t'(2*k+1);
            end else begin
                pair_score[k] = s[2*k];
                pair_idx[k]   = seg_geom_pkg::label_t'(2*k);
            end
        end
        winner = (pair_score[1] > pair_score[0]) ? pair_idx[1] : pair_idx[0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lbl_we     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            lbl_we     <= sif.valid;
            frame_done <= sif.valid && sif.last;
        end
    end

    always_ff @(posedge clk) begin
        if (sif.valid) begin
            lbl_addr <= sif.pix;
            lbl_data <= winner;
        end
    end

endmodule

// File: rtl/class_scorer.sv
// Per-pixel linear class scorer with one multiply-accumulate per class
`timescale 1ns/1ns

module class_scorer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    class_start,
    output seg_geom_pkg::byte_idx_t rd_addr,
    input  seg_geom_pkg::pixel_t    rd_data,
    score_if.scorer                 sif
);

    logic                   busy;
    logic [1:0]             rd_ch;
    seg_geom_pkg::pix_idx_t rd_pix;
    logic                   d_act;
    logic [1:0]             d_ch;
    seg_geom_pkg::pix_idx_t d_pix;
    seg_geom_pkg::score_t   acc  [seg_geom_pkg::NUM_CLASSES];
    seg_geom_pkg::score_t   prod [seg_geom_pkg::NUM_CLASSES];

    // Read address walks all input bytes, one per cycle, no gap between pixels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            rd_addr <= '0;
            rd_ch   <= '0;
            rd_pix  <= '0;
        end else if (class_start) begin
            busy    <= 1'b1;
            rd_addr <= '0;
            rd_ch   <= '0;
            rd_pix  <= '0;
        end else if (busy) begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == seg_geom_pkg::byte_idx_t'(seg_geom_pkg::NUM_BYTES - 1)) begin
                busy <= 1'b0;
            end
            if (rd_ch == 2'(seg_geom_pkg::NUM_CH - 1)) begin
                rd_ch  <= '0;
                rd_pix <= rd_pix + 1'b1;
            end else begin
                rd_ch <= rd_ch + 1'b1;
            end
        end
    end

    // Tags follow the RAM read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_act     <= 1'b0;
            d_ch      <= '0;
            d_pix     <= '0;
            sif.valid <= 1'b0;
            sif.last  <= 1'b0;
        end else begin
            d_act     <= busy;
            d_ch      <= rd_ch;
            d_pix     <= rd_pix;
            sif.valid <= d_act && (d_ch == 2'(seg_geom_pkg::NUM_CH - 1));
            sif.last  <= d_act && (d_ch == 2'(seg_geom_pkg::NUM_CH - 1))
                         && (d_pix == seg_geom_pkg::pix_idx_t'(seg_geom_pkg::NUM_PIX - 1));
        end
    end

    // Signed weight times unsigned channel byte
    always_comb begin
        for (int c = 0; c < seg_geom_pkg::NUM_CLASSES; c++) begin
            prod[c] = seg_geom_pkg::score_t'(seg_geom_pkg::CLASS_WEIGHTS[c][d_ch])
                      * seg_geom_pkg::score_t'({1'b0, rd_data});
        end
    end

    // First channel seeds with the bias, last one lands in the result register
    always_ff @(posedge clk) begin
        if (d_act) begin
            for (int c = 0; c < seg_geom_pkg::NUM_CLASSES; c++) begin
                if (d_ch == 2'd0) begin
                    acc[c] <= seg_geom_pkg::score_t'(seg_geom_pkg::CLASS_BIAS[c]) + prod[c];
                end else if (d_ch == 2'(seg_geom_pkg::NUM_CH - 1)) begin
                    sif.scores[c] <= acc[c] + prod[c];
                end else begin
                    acc[c] <= acc[c] + prod[c];
                end
            end
            sif.pix <= d_pix;
        end
    end

endmodule

// File: rtl/image_loader.sv
// Image loader that fetches packed words from external memory into the input frame buffer
`timescale 1ns/1ns

module image_loader (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 load_start,
    output logic                                 mem_req,
    output logic [seg_ctrl_pkg::MEM_ADDR_W-1:0]  mem_addr,
    input  logic                                 mem_ack,
    input  logic [31:0]                          mem_rdata,
    output logic                                 wr_en,
    output seg_geom_pkg::byte_idx_t              wr_addr,
    output seg_geom_pkg::pixel_t                 wr_data,
    output logic                                 load_done
);

    seg_ctrl_pkg::loader_state_t state;
    logic [7:0]  word_cnt;
    logic [1:0]  byte_sel;
    logic [31:0] word_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= seg_ctrl_pkg::LD_IDLE;
            mem_req  <= 1'b0;
            mem_addr <= '0;
            word_cnt <= '0;
            byte_sel <= '0;
            wr_addr  <= '0;
        end else begin
            case (state)
                seg_ctrl_pkg::LD_IDLE: begin
                    if (load_start) begin
                        mem_addr <= seg_ctrl_pkg::MEM_BASE;
                        mem_req  <= 1'b1;
                        word_cnt <= '0;
                        wr_addr  <= '0;
                        state    <= seg_ctrl_pkg::LD_REQ;
                    end
                end
                // Request and address stay put until the ack
                seg_ctrl_pkg::LD_REQ: begin
                    if (mem_ack) begin
                        mem_req  <= 1'b0;
                        byte_sel <= '0;
                        state    <= seg_ctrl_pkg::LD_UNPACK;
                    end
                end
                seg_ctrl_pkg::LD_UNPACK: begin
                    byte_sel <= byte_sel + 1'b1;
                    wr_addr  <= wr_addr + 1'b1;
                    if (byte_sel == 2'(seg_ctrl_pkg::BYTES_PER_WORD - 1)) begin
                        if (word_cnt == 8'(seg_ctrl_pkg::WORDS_PER_FRAME - 1)) begin
                            state <= seg_ctrl_pkg::LD_FINISH;
                        end else begin
                            mem_addr <= mem_addr + 1'b1;
                            word_cnt <= word_cnt + 1'b1;
                            mem_req  <= 1'b1;
                            state    <= seg_ctrl_pkg::LD_REQ;
                        end
                    end
                end
                seg_ctrl_pkg::LD_FINISH: begin
                    state <= seg_ctrl_pkg::LD_IDLE;
                end
                default: begin
                    state <= seg_ctrl_pkg::LD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == seg_ctrl_pkg::LD_REQ && mem_ack) begin
            word_reg <= mem_rdata;
        end
    end

    // One byte per cycle, lowest byte first
    assign wr_en     = (state == seg_ctrl_pkg::LD_UNPACK);
    assign wr_data   = word_reg[8*byte_sel +: 8];
    assign load_done = (state == seg_ctrl_pkg::LD_FINISH);

endmodule

// File: rtl/frame_ram.sv
// Simple dual-port RAM with one write port and a registered read port
`timescale 1ns/1ns

module frame_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read data appears one cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// File: rtl/score_if.sv
// Interface carrying per-pixel class scores from the scorer to the argmax stage
`timescale 1ns/1ns

interface score_if;

    // One result per valid cycle, no ready since the picker takes one every cycle
    logic                     valid;
    seg_geom_pkg::pix_idx_t   pix;
    seg_geom_pkg::score_vec_t scores;
    // Marks the final pixel of the frame
    logic                     last;

    modport scorer (
        output valid,
        output pix,
        output scores,
        output last
    );

    modport picker (
        input valid,
        input pix,
        input scores,
        input last
    );

endinterface

// File: rtl/seg_ctrl_pkg.sv
// Sequencer and loader state types, external word memory constants
package seg_ctrl_pkg;

    // Values also appear on leds[1:0]
    typedef enum logic [1:0] {
        SEQ_IDLE     = 2'd0,
        SEQ_LOAD     = 2'd1,
        SEQ_CLASSIFY = 2'd2
    } seq_state_t;

    typedef enum logic [1:0] {
        LD_IDLE   = 2'd0,
        LD_REQ    = 2'd1,
        LD_UNPACK = 2'd2,
        LD_FINISH = 2'd3
    } loader_state_t;

    localparam int MEM_ADDR_W = 20;
    localparam logic [MEM_ADDR_W-1:0] MEM_BASE = '0;
    localparam int WORDS_PER_FRAME = 192;

    // Byte 0 sits in bits 7:0 and lands at the lowest byte index
    localparam int BYTES_PER_WORD = 4;

endpackage

// File: rtl/seg_geom_pkg.sv
// Image geometry, class count, pixel and score types, classifier weight and bias tables
package seg_geom_pkg;

    localparam int IMG_W       = 16;
    localparam int IMG_H       = 16;
    localparam int NUM_CH      = 3;
    localparam int NUM_PIX     = IMG_W * IMG_H;
    localparam int NUM_BYTES   = NUM_PIX * NUM_CH;
    localparam int NUM_CLASSES = 4;

    typedef logic [7:0]         pix_idx_t;
    typedef logic [9:0]         byte_idx_t;
    typedef logic [1:0]         label_t;
    typedef logic [7:0]         pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [19:0] score_t;
    typedef score_t [NUM_CLASSES-1:0] score_vec_t;

    // Frame layout is byte 3p+k = channel k of pixel p
    // Score of class c is CLASS_BIAS[c] + sum over k of CLASS_WEIGHTS[c][k] * channel k
    // Largest score wins, lower class index on a tie

    // One row per class, channels in R, G, B order
    localparam weight_t CLASS_WEIGHTS [NUM_CLASSES][NUM_CH] = '{
        '{ 8'sd3, -8'sd1, -8'sd1},
        '{-8'sd1,  8'sd3, -8'sd1},
        '{-8'sd1, -8'sd1,  8'sd3},
        '{ 8'sd1,  8'sd1,  8'sd1}
    };

    // Class 3 is the bright or white class, it needs a clear margin
    localparam logic signed [15:0] CLASS_BIAS [NUM_CLASSES] = '{
        16'sd0,
        16'sd0,
        16'sd0,
        -16'sd200
    };

endpackage
